// File: build.f
verilog/tnn_pkg.sv
verilog/stream_if.sv
verilog/argmax.sv
verilog/winequality_whitetnn.sv
verilog/feature_ingress.sv
verilog/tnn_classify_stage.sv
verilog/prediction_egress.sv
verilog/wine_classifier_top.sv
tests/wine_classifier_assertions.sv
tests/tb_wine_classifier.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_wine_classifier \
    -f build.f -o sim_wine > sim.log 2>&1 \
    && ./obj_dir/sim_wine +verilator+error+limit+100000 >> sim.log 2>&1 \
    || echo "Build or simulation ended abnormally" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log || exit 1
exit 0

// File: tests/tb_wine_classifier.sv
`timescale 1ns/1ns
`default_nettype none

module tb_wine_classifier;

    localparam int RESET_CYCLES = 5;
    localparam int ZERO_CNT = 24;
    localparam int FIXED_REP = 12;
    localparam int RAND_CNT = 240;
    localparam int SAMPLE_CNT = ZERO_CNT + 2 * FIXED_REP + RAND_CNT;
    localparam int TIMEOUT_CYCLES = 4 * SAMPLE_CNT + RESET_CYCLES;
    localparam tnn_pkg::features_t FIXED_A = 44'hfffffffffff;
    localparam tnn_pkg::features_t FIXED_B = 44'h13579bdf024;

    logic                           clk;
    logic                           rst_n;
    logic                           in_valid;
    logic                           in_ready;
    tnn_pkg::features_t             in_features;
    logic                           out_valid;
    logic                           out_ready;
    logic [tnn_pkg::CLASS_BITS-1:0] out_prediction;
    tnn_pkg::tag_t                  out_tag;

    integer seed;
    int     errors;
    int     sent_cnt;
    int     recv_cnt;
    int     cycle_cnt;

    // Samples in flight, oldest first
    tnn_pkg::features_t             exp_feat [$];
    tnn_pkg::tag_t                  exp_tag [$];
    logic [tnn_pkg::CLASS_BITS-1:0] first_pred [tnn_pkg::features_t];

    wine_classifier_top u_wine_classifier_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_features    (in_features),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_prediction (out_prediction),
        .out_tag        (out_tag)
    );

    always #10 clk = ~clk;

    function automatic tnn_pkg::features_t random_features();
        logic [63:0] r;
        r[31:0] = $random(seed);
        r[63:32] = $random(seed);
        return r[tnn_pkg::FEAT_CNT*tnn_pkg::FEAT_BITS-1:0];
    endfunction

    // Called on a rising edge, returns on the edge where the sample was taken
    task automatic send_sample(input tnn_pkg::features_t f, input bit throttle);
        logic [31:0] rnd;
        logic        accepted;
        if (throttle) begin
            rnd = $random(seed);
            while (rnd[1:0] == 2'b00) begin
                in_valid <= 1'b0;
                out_ready <= rnd[2];
                @(posedge clk);
                rnd = $random(seed);
            end
        end
        in_valid <= 1'b1;
        in_features <= f;
        accepted = 1'b0;
        while (!accepted) begin
            rnd = $random(seed);
            out_ready <= throttle ? rnd[0] : 1'b1;
            @(negedge clk);
            accepted = in_ready;
            @(posedge clk);
        end
        exp_feat.push_back(f);
        exp_tag.push_back(tnn_pkg::tag_t'(sent_cnt));
        sent_cnt++;
    endtask

    task automatic check_output();
        tnn_pkg::features_t f;
        tnn_pkg::tag_t      t;
        if (exp_feat.size() == 0) begin
            $display("Output delivered while no sample was outstanding");
            errors++;
            return;
        end
        f = exp_feat.pop_front();
        t = exp_tag.pop_front();
        recv_cnt++;
        if (out_tag !== t) begin
            $display("Fail out_tag: got %h expected %h", out_tag, t);
            errors++;
        end
        // With every feature at zero all computed neurons fire and class 3 scores highest
        if (f == '0 && out_prediction !== 3'd3) begin
            $display("Fail out_prediction: got %h expected %h", out_prediction, 3'd3);
            errors++;
        end
        if (first_pred.exists(f)) begin
            if (out_prediction !== first_pred[f]) begin
                $display("Fail out_prediction: got %h expected %h for features %h",
                         out_prediction, first_pred[f], f);
                errors++;
            end
        end else begin
            first_pred[f] = out_prediction;
        end
    endtask

    task automatic close_run(input bit timed_out);
        int assert_fails;
        assert_fails = u_wine_classifier_top.u_assertions.fail_cnt;
        $display("Sent %0d, received %0d, check errors %0d, assertion failures %0d",
                 sent_cnt, recv_cnt, errors, assert_fails);
        if (!timed_out && errors == 0 && assert_fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            check_output();
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles with %0d samples still outstanding",
                 cycle_cnt, exp_feat.size());
        close_run(1'b1);
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_features = '0;
        out_ready = 1'b0;
        seed = 32'h651e32ef;
        errors = 0;
        sent_cnt = 0;
        recv_cnt = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        // Back-to-back samples with the output always ready
        for (int i = 0; i < ZERO_CNT; i++) begin
            send_sample('0, 1'b0);
        end
        for (int i = 0; i < FIXED_REP; i++) begin
            send_sample(FIXED_A, 1'b0);
        end
        for (int i = 0; i < FIXED_REP; i++) begin
            send_sample(FIXED_B, 1'b0);
        end
        for (int i = 0; i < RAND_CNT; i++) begin
            send_sample(random_features(), 1'b1);
        end
        in_valid <= 1'b0;
        out_ready <= 1'b1;
        while (exp_feat.size() != 0) begin
            @(posedge clk);
        end
        // A few idle cycles so that a duplicated result would still show up
        repeat (4) @(posedge clk);
        close_run(1'b0);
    end

endmodule

`default_nettype wire

// File: tests/wine_classifier_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module wine_classifier_assertions (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           in_valid,
    input logic                           in_ready,
    input logic                           out_valid,
    input logic                           out_ready,
    input logic [tnn_pkg::CLASS_BITS-1:0] out_prediction,
    input tnn_pkg::tag_t                  out_tag
);

    int            fail_cnt = 0;
    int            inflight;
    tnn_pkg::tag_t accept_cnt;

    // Samples accepted but not yet delivered, and the tag the next sample gets
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inflight <= 0;
            accept_cnt <= '0;
        end else begin
            if (in_valid && in_ready) begin
                accept_cnt <= accept_cnt + 1'b1;
            end
            case ({in_valid && in_ready, out_valid && out_ready})
                2'b10: inflight <= inflight + 1;
                2'b01: inflight <= inflight - 1;
                default: inflight <= inflight;
            endcase
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid && !in_ready)
        else begin
            $error("out_valid or in_ready high right after a reset cycle");
            fail_cnt++;
        end

    a_hold_output: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_prediction) && $stable(out_tag))
        else begin
            $error("Stalled output changed or was withdrawn");
            fail_cnt++;
        end

    a_class_range: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_prediction < tnn_pkg::CLASS_CNT)
        else begin
            $error("Prediction outside the class range");
            fail_cnt++;
        end

    // Without a backlog the pipeline never closes its input
    a_ready_free: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) && inflight <= 3 |-> in_ready)
        else begin
            $error("in_ready low with at most three samples in flight");
            fail_cnt++;
        end

    // A sample taken with no backlog leaves exactly three cycles later
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(in_valid && in_ready && inflight <= 3, 3) && $past(out_ready, 3)
            && $past(out_ready, 2) && $past(out_ready, 1)
        |-> out_valid && out_tag == $past(accept_cnt, 3))
        else begin
            $error("Result did not appear three cycles after its input handshake");
            fail_cnt++;
        end

endmodule

bind wine_classifier_top wine_classifier_assertions u_assertions (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_prediction (out_prediction),
    .out_tag        (out_tag)
);

`default_nettype wire

// File: verilog/argmax.sv
`timescale 1ns/1ns
`default_nettype none

module argmax #(
    parameter int SIZE = 2,
    parameter int BITS = 1
) (
    input  logic [SIZE*BITS-1:0]     inx,
    output logic [$clog2(SIZE)-1:0] outimax
);

    logic [BITS-1:0]         best_val;
    logic [$clog2(SIZE)-1:0] best_idx;

    // Walk the scores from index 0 upwards. A later score must be strictly
    // larger to take over, so ties keep the lower index
    always_comb begin
        best_val = inx[BITS-1:0];
        best_idx = '0;
        for (int i = 1; i < SIZE; i++) begin
            if (inx[i*BITS +: BITS] > best_val) begin
                best_val = inx[i*BITS +: BITS];
                best_idx = i[$clog2(SIZE)-1:0];
            end
        end
    end

    assign outimax = best_idx;

endmodule

`default_nettype wire

// File: verilog/feature_ingress.sv
`timescale 1ns/1ns
`default_nettype none

module feature_ingress (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  tnn_pkg::features_t in_features,
    stream_if.source           feat_s
);

    logic               run_q;
    logic               full_q;
    logic               accept;
    tnn_pkg::features_t feat_q;
    tnn_pkg::tag_t      tag_q;
    tnn_pkg::tag_t      tag_cnt_q;

    // Ready when the buffer is empty or is handed downstream this cycle.
    // run_q keeps the input closed until the first cycle after reset
    assign in_ready = run_q && (!full_q || feat_s.ready);
    assign accept = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q <= 1'b0;
            full_q <= 1'b0;
            tag_cnt_q <= '0;
        end else begin
            run_q <= 1'b1;
            if (accept) begin
                full_q <= 1'b1;
                // Wraps at 256 on its own
                tag_cnt_q <= tag_cnt_q + 1'b1;
            end else if (feat_s.ready) begin
                full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            feat_q <= in_features;
            tag_q <= tag_cnt_q;
        end
    end

    assign feat_s.valid = full_q;
    assign feat_s.payload = feat_q;
    assign feat_s.tag = tag_q;

endmodule

`default_nettype wire

// File: verilog/prediction_egress.sv
`timescale 1ns/1ns
`default_nettype none

module prediction_egress (
    input  logic                           clk,
    input  logic                           rst_n,
    stream_if.sink                         res_s,
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic [tnn_pkg::CLASS_BITS-1:0] out_prediction,
    output tnn_pkg::tag_t                  out_tag
);

    tnn_pkg::result_t                  fifo_mem [tnn_pkg::FIFO_DEPTH];
    tnn_pkg::result_t                  head;
    logic [tnn_pkg::FIFO_PTR_BITS-1:0] wr_ptr;
    logic [tnn_pkg::FIFO_PTR_BITS-1:0] rd_ptr;
    logic [tnn_pkg::FIFO_CNT_BITS-1:0] count;
    logic                              wr_en;
    logic                              rd_en;

    assign res_s.ready = (count != tnn_pkg::FIFO_DEPTH[tnn_pkg::FIFO_CNT_BITS-1:0]);
    assign wr_en = res_s.valid && res_s.ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            // Pointers wrap naturally with a power-of-two depth
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            fifo_mem[wr_ptr] <= res_s.payload;
        end
    end

    // Head of the queue is visible the cycle after it is written
    assign head = fifo_mem[rd_ptr];
    assign out_valid = (count != '0);
    assign out_prediction = head.prediction;
    assign out_tag = head.tag;

endmodule

`default_nettype wire

// File: verilog/stream_if.sv
`timescale 1ns/1ns
`default_nettype none

// Valid/ready stream; payload and tag hold steady from valid until the transfer
interface stream_if #(
    parameter type payload_t = logic
);

    logic          valid;
    logic          ready;
    payload_t      payload;
    tnn_pkg::tag_t tag;

    modport source (
        output valid,
        output payload,
        output tag,
        input  ready
    );

    modport sink (
        input  valid,
        input  payload,
        input  tag,
        output ready
    );

endinterface

`default_nettype wire

// File: verilog/tnn_classify_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tnn_classify_stage (
    input  logic     clk,
    input  logic     rst_n,
    stream_if.sink   feat_s,
    stream_if.source res_s
);

    logic [tnn_pkg::CLASS_BITS-1:0] prediction;
    logic                           res_valid_q;
    logic                           take;
    tnn_pkg::result_t               res_q;

    // The whole network settles within the cycle the sample is presented
    winequality_whitetnn u_tnn (
        .features   (feat_s.payload),
        .prediction (prediction)
    );

    // One result slot, free when empty or leaving this cycle
    assign feat_s.ready = !res_valid_q || res_s.ready;
    assign take = feat_s.valid && feat_s.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid_q <= 1'b0;
        end else if (take) begin
            res_valid_q <= 1'b1;
        end else if (res_s.ready) begin
            res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res_q.prediction <= prediction;
            res_q.tag <= feat_s.tag;
        end
    end

    assign res_s.valid = res_valid_q;
    assign res_s.payload = res_q;
    assign res_s.tag = res_q.tag;

endmodule

`default_nettype wire

// File: verilog/tnn_pkg.sv
`default_nettype none

package tnn_pkg;

    // Network sizes fixed by the hard-wired weights
    localparam int FEAT_CNT = 11;
    localparam int FEAT_BITS = 4;
    localparam int HIDDEN_CNT = 40;
    localparam int CLASS_CNT = 7;

    // Popcount of up to HIDDEN_CNT bits, then doubled plus bias
    localparam int SUM_BITS = $clog2(HIDDEN_CNT + 1);
    localparam int SCORE_BITS = SUM_BITS + 1;
    localparam int CLASS_BITS = $clog2(CLASS_CNT);

    // Wide enough for the sum of every feature at its maximum
    localparam int ACC_BITS = $clog2(FEAT_CNT + 1) + FEAT_BITS;

    localparam int TAG_BITS = 8;

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_BITS = $clog2(FIFO_DEPTH + 1);

    // Feature 0 sits in the most significant nibble
    typedef logic [FEAT_CNT*FEAT_BITS-1:0] features_t;

    typedef logic [TAG_BITS-1:0] tag_t;

    typedef struct packed {
        logic [CLASS_BITS-1:0] prediction;
        tag_t                  tag;
    } result_t;

endpackage

`default_nettype wire

// File: verilog/wine_classifier_top.sv
`timescale 1ns/1ns
`default_nettype none

module wine_classifier_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  tnn_pkg::features_t             in_features,
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic [tnn_pkg::CLASS_BITS-1:0] out_prediction,
    output tnn_pkg::tag_t                  out_tag
);

    // Buffered samples towards the network
    stream_if #(.payload_t(tnn_pkg::features_t)) feat_s ();

    // Predictions towards the output queue, tag carried in the payload
    stream_if #(.payload_t(tnn_pkg::result_t)) res_s ();

    feature_ingress u_feature_ingress (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_features (in_features),
        .feat_s      (feat_s.source)
    );

    tnn_classify_stage u_tnn_classify_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .feat_s (feat_s.sink),
        .res_s  (res_s.source)
    );

    prediction_egress u_prediction_egress (
        .clk            (clk),
        .rst_n          (rst_n),
        .res_s          (res_s.sink),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_prediction (out_prediction),
        .out_tag        (out_tag)
    );

endmodule

`default_nettype wire

// File: verilog/winequality_whitetnn.sv
`timescale 1ns/1ns
`default_nettype none

module winequality_whitetnn (
    input  tnn_pkg::features_t             features,
    output logic [tnn_pkg::CLASS_BITS-1:0] prediction
);

    logic [tnn_pkg::HIDDEN_CNT-1:0]                      hidden;
    logic [tnn_pkg::CLASS_CNT*tnn_pkg::SCORE_BITS-1:0] score_vec;

    // Upper half is the positive feature set, lower half the negative one.
    // Bit j selects feature j
    function automatic logic [2*tnn_pkg::FEAT_CNT-1:0] neuron_masks(input int n);
        logic [2*tnn_pkg::FEAT_CNT-1:0] w;
        case (n)
            0:  w = {11'b00010010000, 11'b01100000011};
            2:  w = {11'b11100000100, 11'b00011110000};
            3:  w = {11'b00000100001, 11'b00011010010};
            4:  w = {11'b11000101000, 11'b00000010011};
            5:  w = {11'b00001000000, 11'b00010001100};
            6:  w = {11'b00011011110, 11'b01000000000};
            7:  w = {11'b00000000011, 11'b10011110000};
            8:  w = {11'b00001000110, 11'b01100100001};
            9:  w = {11'b10011010000, 11'b00100001001};
            10: w = {11'b00001101000, 11'b00010000000};
            11: w = {11'b00101010110, 11'b11000100000};
            12: w = {11'b00010100110, 11'b11000000000};
            13: w = {11'b00100010100, 11'b10000100000};
            14: w = {11'b01000001110, 11'b10011010000};
            15: w = {11'b00001000000, 11'b00110001000};
            17: w = {11'b00000100001, 11'b00110010010};
            18: w = {11'b00011001110, 11'b10100000000};
            19: w = {11'b00001000010, 11'b01000111100};
            20: w = {11'b10000100011, 11'b00011010000};
            21: w = {11'b00110000011, 11'b11000001000};
            22: w = {11'b10100000111, 11'b00001101000};
            24: w = {11'b00001000111, 11'b10010101000};
            25: w = {11'b10000001000, 11'b00010010010};
            27: w = {11'b01001011000, 11'b00000000100};
            29: w = {11'b10000100001, 11'b01110001110};
            30: w = {11'b01010111000, 11'b00000000010};
            31: w = {11'b10010100000, 11'b00000000011};
            34: w = {11'b00000111000, 11'b00001000110};
            35: w = {11'b01101000111, 11'b00010011000};
            36: w = {11'b01000000010, 11'b00011100100};
            37: w = {11'b00001000010, 11'b01000111000};
            38: w = {11'b00000000110, 11'b10000000000};
            39: w = {11'b10001100000, 11'b00110010001};
            // Empty sets compare 0 >= 0, so these neurons always fire
            default: w = '0;
        endcase
        return w;
    endfunction

    function automatic logic [tnn_pkg::ACC_BITS-1:0] masked_sum(
        input logic [tnn_pkg::FEAT_CNT-1:0] mask,
        input tnn_pkg::features_t           f
    );
        logic [tnn_pkg::ACC_BITS-1:0] acc;
        acc = '0;
        for (int j = 0; j < tnn_pkg::FEAT_CNT; j++) begin
            if (mask[j]) begin
                acc = acc + {{(tnn_pkg::ACC_BITS - tnn_pkg::FEAT_BITS){1'b0}},
                             f[(tnn_pkg::FEAT_CNT-1-j)*tnn_pkg::FEAT_BITS +: tnn_pkg::FEAT_BITS]};
            end
        end
        return acc;
    endfunction

    // Upper half counts hidden bits that are set, lower half counts cleared ones
    function automatic logic [2*tnn_pkg::HIDDEN_CNT-1:0] class_masks(input int c);
        logic [2*tnn_pkg::HIDDEN_CNT-1:0] m;
        case (c)
            0: m = {40'h0010148890, 40'h4000810642};
            1: m = {40'h6011580880, 40'h04C0810400};
            2: m = {40'h3001140000, 40'h0202000200};
            3: m = {40'h2081818002, 40'h0200000000};
            4: m = {40'h0010400000, 40'h0200211100};
            5: m = {40'h0080000000, 40'h0200812800};
            default: m = {40'h2001142030, 40'h4F48831046};
        endcase
        return m;
    endfunction

    function automatic logic [tnn_pkg::SCORE_BITS-1:0] class_bias(input int c);
        logic [tnn_pkg::SCORE_BITS-1:0] b;
        case (c)
            0: b = 7;
            1: b = 6;
            2: b = 13;
            3: b = 13;
            4: b = 14;
            5: b = 15;
            default: b = 0;
        endcase
        return b;
    endfunction

    function automatic logic [tnn_pkg::SUM_BITS-1:0] class_popcount(
        input logic [tnn_pkg::HIDDEN_CNT-1:0] h,
        input logic [tnn_pkg::HIDDEN_CNT-1:0] on_mask,
        input logic [tnn_pkg::HIDDEN_CNT-1:0] off_mask
    );
        logic [tnn_pkg::SUM_BITS-1:0] cnt;
        cnt = '0;
        for (int k = 0; k < tnn_pkg::HIDDEN_CNT; k++) begin
            if ((h[k] && on_mask[k]) || (!h[k] && off_mask[k])) begin
                cnt = cnt + 1'b1;
            end
        end
        return cnt;
    endfunction

    for (genvar n = 0; n < tnn_pkg::HIDDEN_CNT; n++) begin : g_hidden
        logic [2*tnn_pkg::FEAT_CNT-1:0] w;
        logic [tnn_pkg::ACC_BITS-1:0]   pos_sum;
        logic [tnn_pkg::ACC_BITS-1:0]   neg_sum;

        assign w = neuron_masks(n);
        assign pos_sum = masked_sum(w[2*tnn_pkg::FEAT_CNT-1:tnn_pkg::FEAT_CNT], features);
        assign neg_sum = masked_sum(w[tnn_pkg::FEAT_CNT-1:0], features);
        // Neurons 26 and 28 were pruned to a constant zero
        assign hidden[n] = (n == 26 || n == 28) ? 1'b0 : (pos_sum >= neg_sum);
    end

    for (genvar c = 0; c < tnn_pkg::CLASS_CNT; c++) begin : g_class
        logic [2*tnn_pkg::HIDDEN_CNT-1:0] sel;
        logic [tnn_pkg::SUM_BITS-1:0]     pop;

        assign sel = class_masks(c);
        assign pop = class_popcount(hidden, sel[2*tnn_pkg::HIDDEN_CNT-1:tnn_pkg::HIDDEN_CNT],
                                    sel[tnn_pkg::HIDDEN_CNT-1:0]);
        // Score is 2*popcount + bias
        assign score_vec[c*tnn_pkg::SCORE_BITS +: tnn_pkg::SCORE_BITS] =
            {pop, 1'b0} + class_bias(c);
    end

    argmax #(
        .SIZE (tnn_pkg::CLASS_CNT),
        .BITS (tnn_pkg::SCORE_BITS)
    ) u_argmax (
        .inx     (score_vec),
        .outimax (prediction)
    );

endmodule

`default_nettype wire
